// ==== source/riscMemSys_defines.svh ====
`ifndef RISCMEMSYS_DEFINES_SVH
`define RISCMEMSYS_DEFINES_SVH

// line geometry, shared by cache and backing memory
`define LINE_BYTES 16

// direct-mapped, one line per set
`define CACHE_SETS 8

// 1 KiB backing store
`define MEM_LINES 64

// strobe to memReady, in clk_mem cycles (at least 2)
`define MEM_LATENCY 4

`endif

// ==== source/riscMemSys_pkg.sv ====
`default_nettype none

`include "riscMemSys_defines.svh"

package riscMemSys_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;
	typedef logic [`LINE_BYTES*8-1:0] line_t;

	// address bits 9:7, 6:4 and 9:4
	typedef logic [2:0] tag_t;
	typedef logic [2:0] index_t;
	typedef logic [5:0] lineAddr_t;

	typedef logic [3:0] byteEn_t;

	typedef enum logic {
		LSU_IDLE,
		LSU_WAIT
	} lsuState_e;

	typedef enum logic [1:0] {
		CACHE_IDLE,
		CACHE_FILL,
		CACHE_MERGE,
		CACHE_WRITE
	} cacheState_e;

endpackage

`default_nettype wire

// ==== source/memReqIf.sv ====
`default_nettype none

interface memReqIf;
	import riscMemSys_pkg::*;

	// strobes from the front end
	logic read;
	logic write;
	addr_t addr;
	word_t writeData;
	byteEn_t byteEn;

	// response from the cache
	logic ready;
	word_t readData;

	modport requester (
		output read, write, addr, writeData, byteEn,
		input ready, readData
	);

	modport responder (
		input read, write, addr, writeData, byteEn,
		output ready, readData
	);

endinterface

`default_nettype wire

// ==== source/lineBusIf.sv ====
`default_nettype none

interface lineBusIf;
	import riscMemSys_pkg::*;

	logic memRead;
	logic memWrite;
	lineAddr_t lineAddr;
	line_t writeLine;

	// returned MEM_LATENCY cycles after either strobe
	logic memReady;
	line_t readLine;

	modport requester (
		output memRead, memWrite, lineAddr, writeLine,
		input memReady, readLine
	);

	modport responder (
		input memRead, memWrite, lineAddr, writeLine,
		output memReady, readLine
	);

endinterface

`default_nettype wire

// ==== source/loadStoreUnit.sv ====
`default_nettype none

module loadStoreUnit (
	input wire logic clk_mem,
	input wire logic rst,
	input wire logic instrValid_i,
	input riscMemSys_pkg::word_t instr_i,
	input riscMemSys_pkg::word_t base_i,
	input riscMemSys_pkg::word_t storeData_i,
	output logic busy_o,
	output logic loadValid_o,
	output riscMemSys_pkg::word_t loadData_o,
	output logic storeDone_o,
	memReqIf.requester req
);
	import riscMemSys_pkg::*;

	lsuState_e state;

	logic isLoad;
	logic isStore;
	logic accept;
	logic [2:0] funct3;
	word_t immI;
	word_t immS;
	addr_t effAddr;
	word_t laneData;
	byteEn_t laneEn;

	// held for the whole access
	logic [2:0] funct3Q;
	logic [1:0] offQ;
	logic isStoreQ;

	word_t byteLane;
	logic [15:0] halfLane;
	word_t loadResult;

	// same opcode tests as the core decoder
	assign isLoad = (instr_i[6:2] == 5'b00000);
	assign isStore = (instr_i[6:2] == 5'b01000);
	assign funct3 = instr_i[14:12];

	assign immI = {{20{instr_i[31]}}, instr_i[31:20]};
	assign immS = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
	assign effAddr = base_i + (isStore ? immS : immI);

	assign busy_o = (state == LSU_WAIT) || loadValid_o || storeDone_o;
	assign accept = instrValid_i && !busy_o && (isLoad || isStore);

	// replicate into every lane, byteEn picks the live ones
	always_comb begin
		case (funct3[1:0])
			2'b00: begin
				laneData = {4{storeData_i[7:0]}};
				laneEn = byteEn_t'(4'b0001 << effAddr[1:0]);
			end
			2'b01: begin
				laneData = {2{storeData_i[15:0]}};
				laneEn = effAddr[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				laneData = storeData_i;
				laneEn = 4'b1111;
			end
		endcase
	end

	// lane select and extension, bit 2 of funct3 means unsigned
	assign byteLane = req.readData >> {offQ, 3'b000};
	assign halfLane = offQ[1] ? req.readData[31:16] : req.readData[15:0];

	always_comb begin
		case (funct3Q[1:0])
			2'b00: loadResult = funct3Q[2] ? {24'b0, byteLane[7:0]}
				: {{24{byteLane[7]}}, byteLane[7:0]};
			2'b01: loadResult = funct3Q[2] ? {16'b0, halfLane}
				: {{16{halfLane[15]}}, halfLane};
			default: loadResult = req.readData;
		endcase
	end

	always_ff @(posedge clk_mem) begin
		if (rst) begin
			state <= LSU_IDLE;
			req.read <= 1'b0;
			req.write <= 1'b0;
			loadValid_o <= 1'b0;
			storeDone_o <= 1'b0;
		end else begin
			req.read <= 1'b0;
			req.write <= 1'b0;
			loadValid_o <= 1'b0;
			storeDone_o <= 1'b0;
			case (state)
				LSU_IDLE: begin
					if (accept) begin
						state <= LSU_WAIT;
						req.read <= isLoad;
						req.write <= isStore;
					end
				end
				LSU_WAIT: begin
					if (req.ready) begin
						state <= LSU_IDLE;
						loadValid_o <= !isStoreQ;
						storeDone_o <= isStoreQ;
					end
				end
				default: state <= LSU_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_mem) begin
		if (accept) begin
			req.addr <= {effAddr[31:2], 2'b00};
			req.writeData <= laneData;
			req.byteEn <= laneEn;
			offQ <= effAddr[1:0];
			funct3Q <= funct3;
			isStoreQ <= isStore;
		end
		if (state == LSU_WAIT && req.ready) begin
			loadData_o <= loadResult;
		end
	end

endmodule

`default_nettype wire

// ==== source/l1DataCache.sv ====
`default_nettype none

`include "riscMemSys_defines.svh"

module l1DataCache (
	input wire logic clk_mem,
	input wire logic rst,
	memReqIf.responder cpu,
	lineBusIf.requester mem,
	output logic missPulse_o
);
	import riscMemSys_pkg::*;

	cacheState_e state;

	logic [`CACHE_SETS-1:0] validBits;
	tag_t tagMem [`CACHE_SETS];
	line_t dataMem [`CACHE_SETS];

	// request latched at the strobe
	addr_t reqAddr;
	word_t reqWriteData;
	byteEn_t reqByteEn;
	logic reqIsWrite;

	logic strobe;
	index_t strobeIndex;
	tag_t strobeTag;
	logic hit;

	index_t reqIndex;
	tag_t reqTag;
	logic [1:0] reqWord;
	line_t oldLine;
	word_t mergedWord;
	line_t mergedLine;

	assign strobe = (state == CACHE_IDLE) && (cpu.read || cpu.write);
	assign strobeIndex = cpu.addr[6:4];
	assign strobeTag = cpu.addr[9:7];
	assign hit = validBits[strobeIndex] && (tagMem[strobeIndex] == strobeTag);

	assign reqIndex = reqAddr[6:4];
	assign reqTag = reqAddr[9:7];
	assign reqWord = reqAddr[3:2];
	assign oldLine = dataMem[reqIndex];

	// store merge into the resident line
	always_comb begin
		mergedWord = oldLine[reqWord*32 +: 32];
		for (int b = 0; b < 4; b++) begin
			if (reqByteEn[b]) begin
				mergedWord[b*8 +: 8] = reqWriteData[b*8 +: 8];
			end
		end
		mergedLine = oldLine;
		mergedLine[reqWord*32 +: 32] = mergedWord;
	end

	always_ff @(posedge clk_mem) begin
		if (rst) begin
			state <= CACHE_IDLE;
			validBits <= '0;
			cpu.ready <= 1'b0;
			mem.memRead <= 1'b0;
			mem.memWrite <= 1'b0;
			missPulse_o <= 1'b0;
		end else begin
			cpu.ready <= 1'b0;
			mem.memRead <= 1'b0;
			mem.memWrite <= 1'b0;
			missPulse_o <= 1'b0;
			case (state)
				CACHE_IDLE: begin
					if (strobe) begin
						if (!hit) begin
							// write-allocate, so stores fill too
							mem.memRead <= 1'b1;
							missPulse_o <= 1'b1;
							state <= CACHE_FILL;
						end else if (cpu.write) begin
							state <= CACHE_MERGE;
						end else begin
							cpu.ready <= 1'b1;
						end
					end
				end
				CACHE_FILL: begin
					if (mem.memReady) begin
						validBits[reqIndex] <= 1'b1;
						if (reqIsWrite) begin
							state <= CACHE_MERGE;
						end else begin
							cpu.ready <= 1'b1;
							state <= CACHE_IDLE;
						end
					end
				end
				CACHE_MERGE: begin
					mem.memWrite <= 1'b1;
					state <= CACHE_WRITE;
				end
				CACHE_WRITE: begin
					if (mem.memReady) begin
						cpu.ready <= 1'b1;
						state <= CACHE_IDLE;
					end
				end
				default: state <= CACHE_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_mem) begin
		if (strobe) begin
			reqAddr <= cpu.addr;
			reqWriteData <= cpu.writeData;
			reqByteEn <= cpu.byteEn;
			reqIsWrite <= cpu.write;
			mem.lineAddr <= cpu.addr[9:4];
			// hit data, replaced below on a fill
			cpu.readData <= dataMem[strobeIndex][cpu.addr[3:2]*32 +: 32];
		end
		if (state == CACHE_FILL && mem.memReady) begin
			dataMem[reqIndex] <= mem.readLine;
			tagMem[reqIndex] <= reqTag;
			cpu.readData <= mem.readLine[reqWord*32 +: 32];
		end
		if (state == CACHE_MERGE) begin
			dataMem[reqIndex] <= mergedLine;
			mem.writeLine <= mergedLine;
		end
	end

endmodule

`default_nettype wire

// ==== source/lineMemory.sv ====
`default_nettype none

`include "riscMemSys_defines.svh"

module lineMemory (
	input wire logic clk_mem,
	input wire logic rst,
	lineBusIf.responder bus
);
	import riscMemSys_pkg::*;

	localparam int CountW = $clog2(`MEM_LATENCY + 1);

	line_t lineArray [`MEM_LINES];

	logic [CountW-1:0] count;
	logic strobe;

	lineAddr_t addrQ;
	line_t writeLineQ;
	logic isWriteQ;

	assign strobe = bus.memRead || bus.memWrite;

	// countdown, ready leaves on the last step
	always_ff @(posedge clk_mem) begin
		if (rst) begin
			count <= '0;
			bus.memReady <= 1'b0;
		end else begin
			bus.memReady <= (count == CountW'(1));
			if (strobe) begin
				count <= CountW'(`MEM_LATENCY - 1);
			end else if (count != '0) begin
				count <= count - CountW'(1);
			end
		end
	end

	always_ff @(posedge clk_mem) begin
		if (strobe) begin
			addrQ <= bus.lineAddr;
			writeLineQ <= bus.writeLine;
			isWriteQ <= bus.memWrite;
		end
		if (count == CountW'(1)) begin
			bus.readLine <= lineArray[addrQ];
			if (isWriteQ) begin
				lineArray[addrQ] <= writeLineQ;
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/riscMemSys.sv ====
`default_nettype none

module riscMemSys (
	input wire logic clk_mem,
	input wire logic rst,
	input wire logic instrValid_i,
	input riscMemSys_pkg::word_t instr_i,
	input riscMemSys_pkg::word_t base_i,
	input riscMemSys_pkg::word_t storeData_i,
	output logic busy_o,
	output logic loadValid_o,
	output riscMemSys_pkg::word_t loadData_o,
	output logic storeDone_o,
	output logic l1Miss_o,
	output logic memRead_o,
	output logic memWrite_o
);

	memReqIf reqBus ();
	lineBusIf lineBus ();

	loadStoreUnit lsuInst (
		.clk_mem (clk_mem),
		.rst (rst),
		.instrValid_i (instrValid_i),
		.instr_i (instr_i),
		.base_i (base_i),
		.storeData_i (storeData_i),
		.busy_o (busy_o),
		.loadValid_o (loadValid_o),
		.loadData_o (loadData_o),
		.storeDone_o (storeDone_o),
		.req (reqBus.requester)
	);

	l1DataCache cacheInst (
		.clk_mem (clk_mem),
		.rst (rst),
		.cpu (reqBus.responder),
		.mem (lineBus.requester),
		.missPulse_o (l1Miss_o)
	);

	lineMemory memInst (
		.clk_mem (clk_mem),
		.rst (rst),
		.bus (lineBus.responder)
	);

	// line bus strobes for observation
	assign memRead_o = lineBus.memRead;
	assign memWrite_o = lineBus.memWrite;

endmodule

`default_nettype wire

// ==== verification/riscMemSys_asserts.sv ====
`default_nettype none

module riscMemSys_asserts (
	input wire logic clk_mem,
	input wire logic rst,
	input wire logic busy_o,
	input wire logic loadValid_o,
	input wire logic storeDone_o,
	input wire logic l1Miss_o,
	input wire logic memRead_o,
	input wire logic memWrite_o
);
	timeunit 1ns;
	timeprecision 1ps;

	oneResponse: assert property (@(posedge clk_mem) disable iff (rst)
		!(loadValid_o && storeDone_o))
		else $error("load and store responses in the same cycle");

	// a response only ends an access already in flight
	responseAfterBusy: assert property (@(posedge clk_mem) disable iff (rst)
		(loadValid_o || storeDone_o) |-> $past(busy_o))
		else $error("response pulse without busy in the previous cycle");

	oneLineTransfer: assert property (@(posedge clk_mem) disable iff (rst)
		!(memRead_o && memWrite_o))
		else $error("line read and line write strobes together");

	resetQuiet: assert property (@(posedge clk_mem)
		rst |=> !(busy_o || loadValid_o || storeDone_o || l1Miss_o || memRead_o || memWrite_o))
		else $error("control output high after reset");

endmodule

bind riscMemSys riscMemSys_asserts assertsInst (
	.clk_mem (clk_mem),
	.rst (rst),
	.busy_o (busy_o),
	.loadValid_o (loadValid_o),
	.storeDone_o (storeDone_o),
	.l1Miss_o (l1Miss_o),
	.memRead_o (memRead_o),
	.memWrite_o (memWrite_o)
);

`default_nettype wire

// ==== verification/riscMemSys_tb.sv ====
`default_nettype none

`include "riscMemSys_defines.svh"

module riscMemSys_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import riscMemSys_pkg::*;

	// worst case per access is a store miss, fill plus write-through
	localparam int OpCycles = 2 * `MEM_LATENCY + 6;
	localparam int CycleLimit = 2 * 6 * 64 * OpCycles;

	logic clk_mem;
	logic rst;
	logic instrValid;
	word_t instr;
	word_t base;
	word_t storeData;
	logic busy;
	logic loadValid;
	word_t loadData;
	logic storeDone;
	logic l1Miss;
	logic memRead;
	logic memWrite;

	logic [7:0] refMem [1024];
	logic refWritten [1024];
	int errors = 0;
	int cycles = 0;
	int missCount = 0;
	int readCount = 0;
	int writeCount = 0;
	int missDelta;
	int readDelta;
	int writeDelta;
	integer seed = 32'h2ccc;

	riscMemSys riscMemSys_inst (
		.clk_mem (clk_mem),
		.rst (rst),
		.instrValid_i (instrValid),
		.instr_i (instr),
		.base_i (base),
		.storeData_i (storeData),
		.busy_o (busy),
		.loadValid_o (loadValid),
		.loadData_o (loadData),
		.storeDone_o (storeDone),
		.l1Miss_o (l1Miss),
		.memRead_o (memRead),
		.memWrite_o (memWrite)
	);

	initial begin
		clk_mem = 1'b0;
		forever #20 clk_mem = ~clk_mem;
	end

	always @(posedge clk_mem) begin
		cycles <= cycles + 1;
		if (cycles >= CycleLimit) begin
			$display("timeout after %0d cycles, the DUT stopped making progress", cycles);
			$display("Test failed");
			$finish;
		end
	end

	// pulse counters for the miss and line bus strobes
	always @(negedge clk_mem) begin
		if (l1Miss) missCount <= missCount + 1;
		if (memRead) readCount <= readCount + 1;
		if (memWrite) writeCount <= writeCount + 1;
	end

	task automatic checkValue(input string name, input word_t expected, input word_t actual);
		if (expected !== actual) begin
			errors++;
			$display("ERROR %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	function automatic logic [9:0] alignAddr(input logic [2:0] f3, input logic [9:0] a);
		case (f3[1:0])
			2'b00: return a;
			2'b01: return {a[9:1], 1'b0};
			default: return {a[9:2], 2'b00};
		endcase
	endfunction

	function automatic int sizeOf(input logic [2:0] f3);
		return 1 << f3[1:0];
	endfunction

	function automatic word_t expectLoad(input logic [2:0] f3, input logic [9:0] a);
		logic [9:0] p;
		p = alignAddr(f3, a);
		case (f3)
			3'b000: return {{24{refMem[p][7]}}, refMem[p]};
			3'b100: return {24'b0, refMem[p]};
			3'b001: return {{16{refMem[p + 10'd1][7]}}, refMem[p + 10'd1], refMem[p]};
			3'b101: return {16'b0, refMem[p + 10'd1], refMem[p]};
			default: return {refMem[p + 10'd3], refMem[p + 10'd2], refMem[p + 10'd1], refMem[p]};
		endcase
	endfunction

	function automatic logic isWritten(input logic [2:0] f3, input logic [9:0] a);
		logic all;
		all = 1'b1;
		for (int i = 0; i < sizeOf(f3); i++) begin
			all = all & refWritten[alignAddr(f3, a) + 10'(i)];
		end
		return all;
	endfunction

	task automatic writeModel(input logic [2:0] f3, input logic [9:0] a, input word_t d);
		logic [9:0] p;
		p = alignAddr(f3, a);
		for (int i = 0; i < sizeOf(f3); i++) begin
			refMem[p + 10'(i)] = d[8*i +: 8];
			refWritten[p + 10'(i)] = 1'b1;
		end
	endtask

	// assemble, issue, wait for the response, then check against the model
	task automatic runAccess(input string name, input logic isStore, input logic [2:0] f3,
			input word_t baseVal, input logic [11:0] imm, input word_t data);
		word_t ea;
		int startMiss;
		int startRead;
		int startWrite;
		int waited;
		logic done;
		ea = baseVal + {{20{imm[11]}}, imm};
		startMiss = missCount;
		startRead = readCount;
		startWrite = writeCount;
		@(posedge clk_mem);
		instrValid <= 1'b1;
		instr <= isStore ? {imm[11:5], 5'd4, 5'd2, f3, imm[4:0], 7'b0100011}
			: {imm, 5'd2, f3, 5'd3, 7'b0000011};
		base <= baseVal;
		storeData <= data;
		@(posedge clk_mem);
		instrValid <= 1'b0;
		waited = 0;
		done = 1'b0;
		while (!done && waited < 4 * OpCycles) begin
			@(negedge clk_mem);
			waited++;
			done = loadValid || storeDone;
		end
		if (!done) begin
			errors++;
			$display("%s: no response from the DUT within %0d cycles", name, waited);
		end else if (storeDone !== isStore) begin
			errors++;
			$display("%s: the DUT answered with the wrong kind of response", name);
		end else if (isStore) begin
			writeModel(f3, ea[9:0], data);
		end else begin
			checkValue(name, expectLoad(f3, ea[9:0]), loadData);
		end
		missDelta = missCount - startMiss;
		readDelta = readCount - startRead;
		writeDelta = writeCount - startWrite;
	endtask

	task automatic checkPulses(input string name, input int m, input int r, input int w);
		checkValue({name, " l1Miss"}, m, missDelta);
		checkValue({name, " memRead"}, r, readDelta);
		checkValue({name, " memWrite"}, w, writeDelta);
	endtask

	task automatic resetAndIgnore();
		logic seen;
		@(negedge clk_mem);
		checkValue("reset outputs", 32'd0,
			32'({busy, loadValid, storeDone, l1Miss, memRead, memWrite}));
		@(posedge clk_mem);
		instrValid <= 1'b1;
		instr <= 32'h002081b3;
		@(posedge clk_mem);
		instrValid <= 1'b0;
		seen = 1'b0;
		repeat (2 * OpCycles) begin
			@(negedge clk_mem);
			seen = seen | busy | loadValid | storeDone | memRead;
		end
		if (seen) begin
			errors++;
			$display("an ALU instruction caused busy or a memory response");
		end
	endtask

	task automatic wordAccess();
		runAccess("sw positive imm", 1'b1, 3'b010, 32'h100, 12'h008, 32'hdeadbeef);
		runAccess("sw negative imm", 1'b1, 3'b010, 32'h120, 12'hff8, 32'h12345678);
		runAccess("lw negative imm", 1'b0, 3'b010, 32'h110, 12'hff8, 32'h0);
		runAccess("lw positive imm", 1'b0, 3'b010, 32'h100, 12'h018, 32'h0);
	endtask

	task automatic byteHalfAccess();
		runAccess("sw clear", 1'b1, 3'b010, 32'h200, 12'h000, 32'h0);
		runAccess("sb lane 0", 1'b1, 3'b000, 32'h200, 12'h000, 32'h00000081);
		runAccess("sb lane 1", 1'b1, 3'b000, 32'h200, 12'h001, 32'h0000007f);
		runAccess("sh upper", 1'b1, 3'b001, 32'h200, 12'h002, 32'h00008001);
		runAccess("lb negative", 1'b0, 3'b000, 32'h200, 12'h000, 32'h0);
		runAccess("lbu", 1'b0, 3'b100, 32'h200, 12'h000, 32'h0);
		runAccess("lb positive", 1'b0, 3'b000, 32'h200, 12'h001, 32'h0);
		runAccess("lh negative", 1'b0, 3'b001, 32'h200, 12'h002, 32'h0);
		runAccess("lhu", 1'b0, 3'b101, 32'h200, 12'h002, 32'h0);
		runAccess("lh odd address", 1'b0, 3'b001, 32'h200, 12'h003, 32'h0);
		runAccess("lh lower", 1'b0, 3'b001, 32'h200, 12'h000, 32'h0);
		runAccess("lw merged", 1'b0, 3'b010, 32'h200, 12'h000, 32'h0);
	endtask

	task automatic missAndHit();
		runAccess("store new line", 1'b1, 3'b010, 32'h300, 12'h000, 32'ha5a55a5a);
		checkPulses("store new line", 1, 1, 1);
		runAccess("load same line", 1'b0, 3'b010, 32'h300, 12'h004, 32'h0);
		checkPulses("load same line", 0, 0, 0);
		runAccess("store same line", 1'b1, 3'b010, 32'h300, 12'h008, 32'h0badf00d);
		checkPulses("store same line", 0, 0, 1);
	endtask

	// 0x040 and 0x0c0 share index 4 with tags 0 and 1
	task automatic conflictEviction();
		runAccess("conflict store a", 1'b1, 3'b010, 32'h040, 12'h000, 32'h11112222);
		runAccess("conflict store b", 1'b1, 3'b010, 32'h0c0, 12'h000, 32'h33334444);
		checkPulses("conflict store b", 1, 1, 1);
		for (int i = 0; i < 4; i++) begin
			runAccess($sformatf("conflict load a %0d", i), 1'b0, 3'b010, 32'h040, 12'h0, 32'h0);
			checkValue($sformatf("conflict miss a %0d", i), 32'd1, missDelta);
			runAccess($sformatf("conflict load b %0d", i), 1'b0, 3'b010, 32'h0c0, 12'h0, 32'h0);
			checkValue($sformatf("conflict miss b %0d", i), 32'd1, missDelta);
		end
	endtask

	task automatic randomSequence();
		word_t r;
		word_t d;
		logic [9:0] a;
		logic [2:0] f3;
		logic [11:0] imm;
		logic isStore;
		for (int i = 0; i < 48; i++) begin
			r = $random(seed);
			d = $random(seed);
			f3[1:0] = (r[11:10] == 2'b11) ? 2'b10 : r[11:10];
			f3[2] = r[12] && (f3[1:0] != 2'b10);
			a = alignAddr(f3, r[9:0]);
			imm = r[27:16];
			// loads only where the model holds data
			isStore = r[31] || !isWritten(f3, a);
			if (isStore) f3[2] = 1'b0;
			runAccess($sformatf("random op %0d", i), isStore, f3,
				{22'b0, a} - {{20{imm[11]}}, imm}, imm, d);
		end
	endtask

	initial begin
		for (int i = 0; i < 1024; i++) begin
			refWritten[i] = 1'b0;
		end
		rst <= 1'b1;
		instrValid <= 1'b0;
		instr <= '0;
		base <= '0;
		storeData <= '0;
		repeat (8) @(posedge clk_mem);
		rst <= 1'b0;
		resetAndIgnore();
		wordAccess();
		byteHalfAccess();
		missAndHit();
		conflictEviction();
		randomSequence();
		$display("run finished with %0d errors", errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== riscMemSys.f ====
+incdir+source
source/riscMemSys_pkg.sv
source/memReqIf.sv
source/lineBusIf.sv
source/loadStoreUnit.sv
source/l1DataCache.sv
source/lineMemory.sv
source/riscMemSys.sv
verification/riscMemSys_asserts.sv
verification/riscMemSys_tb.sv

// ==== build.sh ====
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module riscMemSys_tb \
	-f riscMemSys.f -o simv || { echo "Verilator build failed"; exit 1; }
./obj_dir/simv > sim.log 2>&1 || echo "Test failed: simulator exit status" >> sim.log
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0
